// File: rtl/backend_cfg_pkg.sv
`default_nettype none

package backend_cfg_pkg;

  // Architectural sizes
  localparam int unsigned XLEN      = 32;
  localparam int unsigned NUM_AREGS = 32;
  localparam int unsigned AREG_W    = 5;

  // ROB_DEPTH in the design must be a power of two, at most this
  localparam int unsigned MAX_ROB_DEPTH = 16;

  typedef logic [$clog2(MAX_ROB_DEPTH)-1:0] rob_tag_t;

endpackage

`default_nettype wire

// File: rtl/uop_pkg.sv
`default_nettype none

package uop_pkg;

  typedef enum logic [2:0] {
    OP_ADD, OP_SUB, OP_AND, OP_OR,
    OP_XOR, OP_SLL, OP_SRL, OP_ADDI
  } alu_op_e;

  // Decoded uop, ADDI takes imm in place of rs2
  typedef struct packed {
    alu_op_e                            op;
    logic [backend_cfg_pkg::AREG_W-1:0] rd;
    logic [backend_cfg_pkg::AREG_W-1:0] rs1;
    logic [backend_cfg_pkg::AREG_W-1:0] rs2;
    logic [backend_cfg_pkg::XLEN-1:0]   imm;
  } uop_t;

  // Source operand, value valid once ready
  typedef struct packed {
    logic                             ready;
    backend_cfg_pkg::rob_tag_t        tag;
    logic [backend_cfg_pkg::XLEN-1:0] value;
  } operand_t;

  typedef struct packed {
    alu_op_e                          op;
    logic [backend_cfg_pkg::XLEN-1:0] imm;
    backend_cfg_pkg::rob_tag_t        dst;
    operand_t                         src1;
    operand_t                         src2;
  } iq_entry_t;

  // Result bus
  typedef struct packed {
    logic                             valid;
    backend_cfg_pkg::rob_tag_t        tag;
    logic [backend_cfg_pkg::XLEN-1:0] data;
  } cdb_t;

  typedef struct packed {
    logic [backend_cfg_pkg::AREG_W-1:0] areg;
    logic [backend_cfg_pkg::XLEN-1:0]   data;
  } commit_t;

endpackage

`default_nettype wire

// File: rtl/arf.sv
`timescale 1ns/1ps
`default_nettype none

module arf (
  input  logic                                    clk_i,
  input  logic                                    rst_n_i,
  input  logic                                    we_i,
  input  logic [backend_cfg_pkg::AREG_W-1:0]      waddr_i,
  input  logic [backend_cfg_pkg::XLEN-1:0]        wdata_i,
  input  logic [1:0][backend_cfg_pkg::AREG_W-1:0] raddr_i,
  output logic [1:0][backend_cfg_pkg::XLEN-1:0]   rdata_o
);

  logic [backend_cfg_pkg::XLEN-1:0] regs_q [backend_cfg_pkg::NUM_AREGS];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int r = 0; r < backend_cfg_pkg::NUM_AREGS; r++) begin
        regs_q[r] <= '0;
      end
    end else if (we_i && waddr_i != '0) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // Retiring value is visible in the same cycle
  always_comb begin
    for (int i = 0; i < 2; i++) begin
      if (raddr_i[i] == '0) begin
        rdata_o[i] = '0;
      end else if (we_i && waddr_i == raddr_i[i]) begin
        rdata_o[i] = wdata_i;
      end else begin
        rdata_o[i] = regs_q[raddr_i[i]];
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/rob.sv
`timescale 1ns/1ps
`default_nettype none

module rob #(
  parameter int unsigned ROB_DEPTH = 8
) (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,
  input  logic                                  flush_i,
  input  logic                                  alloc_valid_i,
  input  logic [backend_cfg_pkg::AREG_W-1:0]    alloc_rd_i,
  input  uop_pkg::cdb_t                         cdb_i,
  input  backend_cfg_pkg::rob_tag_t [1:0]       query_tag_i,
  input  logic                                  commit_ready_i,
  output logic                                  alloc_ready_o,
  output backend_cfg_pkg::rob_tag_t             alloc_tag_o,
  output logic [1:0]                            query_ready_o,
  output logic [1:0][backend_cfg_pkg::XLEN-1:0] query_data_o,
  output logic                                  commit_valid_o,
  output uop_pkg::commit_t                      commit_o,
  output logic                                  commit_fire_o,
  output backend_cfg_pkg::rob_tag_t             commit_tag_o
);

  localparam int unsigned PTR_W = $clog2(ROB_DEPTH);

  logic [PTR_W-1:0]                   head_q;
  logic [PTR_W-1:0]                   tail_q;
  logic [PTR_W:0]                     count_q;
  logic [ROB_DEPTH-1:0]               done_q;
  logic [backend_cfg_pkg::AREG_W-1:0] areg_q [ROB_DEPTH];
  logic [backend_cfg_pkg::XLEN-1:0]   data_q [ROB_DEPTH];
  logic                               alloc_fire;
  logic [PTR_W-1:0]                   cdb_idx;

  assign alloc_ready_o = (count_q != (PTR_W+1)'(ROB_DEPTH));
  assign alloc_tag_o   = backend_cfg_pkg::rob_tag_t'(tail_q);
  assign alloc_fire    = alloc_valid_i && alloc_ready_o;
  assign cdb_idx       = cdb_i.tag[PTR_W-1:0];

  // Operand lookup for renamed sources
  always_comb begin
    for (int i = 0; i < 2; i++) begin
      query_ready_o[i] = done_q[query_tag_i[i][PTR_W-1:0]];
      query_data_o[i]  = data_q[query_tag_i[i][PTR_W-1:0]];
    end
  end

  // ========================================
  // In-order retire from the head
  // ========================================
  assign commit_valid_o = (count_q != '0) && done_q[head_q] && !flush_i;
  assign commit_fire_o  = commit_valid_o && commit_ready_i;
  assign commit_tag_o   = backend_cfg_pkg::rob_tag_t'(head_q);
  assign commit_o.areg  = areg_q[head_q];
  assign commit_o.data  = data_q[head_q];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || flush_i) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
      done_q  <= '0;
    end else begin
      if (alloc_fire) begin
        tail_q         <= tail_q + PTR_W'(1);
        done_q[tail_q] <= 1'b0;
      end
      if (cdb_i.valid) begin
        done_q[cdb_idx] <= 1'b1;
      end
      if (commit_fire_o) begin
        head_q <= head_q + PTR_W'(1);
      end
      case ({alloc_fire, commit_fire_o})
        2'b10:   count_q <= count_q + (PTR_W+1)'(1);
        2'b01:   count_q <= count_q - (PTR_W+1)'(1);
        default: count_q <= count_q;
      endcase
    end
  end

  // Entry payload
  always_ff @(posedge clk_i) begin
    if (alloc_fire) begin
      areg_q[tail_q] <= alloc_rd_i;
    end
    if (cdb_i.valid) begin
      data_q[cdb_idx] <= cdb_i.data;
    end
  end

endmodule

`default_nettype wire

// File: rtl/issue_queue.sv
`timescale 1ns/1ps
`default_nettype none

module issue_queue #(
  parameter int unsigned IQ_DEPTH = 4
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               flush_i,
  input  logic               push_i,
  input  uop_pkg::iq_entry_t entry_i,
  input  uop_pkg::cdb_t      cdb_i,
  output logic               ready_o,
  output logic               issue_valid_o,
  output uop_pkg::iq_entry_t issue_entry_o
);

  localparam int unsigned IDX_W = (IQ_DEPTH > 1) ? $clog2(IQ_DEPTH) : 1;

  logic [IQ_DEPTH-1:0] valid_q;
  uop_pkg::iq_entry_t  slot_q [IQ_DEPTH];
  logic [IDX_W-1:0]    free_idx;
  logic [IDX_W-1:0]    issue_idx;
  uop_pkg::iq_entry_t  push_entry;

  // Capture a broadcast result into a waiting operand
  function automatic uop_pkg::operand_t wakeup(
    input uop_pkg::operand_t opnd,
    input uop_pkg::cdb_t     cdb
  );
    uop_pkg::operand_t res;
    res = opnd;
    if (!opnd.ready && cdb.valid && cdb.tag == opnd.tag) begin
      res.ready = 1'b1;
      res.value = cdb.data;
    end
    return res;
  endfunction

  // Lowest free slot and lowest ready slot
  always_comb begin
    ready_o       = 1'b0;
    free_idx      = '0;
    issue_valid_o = 1'b0;
    issue_idx     = '0;
    for (int i = IQ_DEPTH - 1; i >= 0; i--) begin
      if (!valid_q[i]) begin
        ready_o  = 1'b1;
        free_idx = IDX_W'(i);
      end
      if (valid_q[i] && slot_q[i].src1.ready && slot_q[i].src2.ready) begin
        issue_valid_o = 1'b1;
        issue_idx     = IDX_W'(i);
      end
    end
  end

  assign issue_entry_o = slot_q[issue_idx];

  always_comb begin
    push_entry      = entry_i;
    push_entry.src1 = wakeup(entry_i.src1, cdb_i);
    push_entry.src2 = wakeup(entry_i.src2, cdb_i);
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || flush_i) begin
      valid_q <= '0;
    end else begin
      if (issue_valid_o) begin
        valid_q[issue_idx] <= 1'b0;
      end
      if (push_i && ready_o) begin
        valid_q[free_idx] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < IQ_DEPTH; i++) begin
      if (push_i && ready_o && free_idx == IDX_W'(i)) begin
        slot_q[i] <= push_entry;
      end else begin
        slot_q[i].src1 <= wakeup(slot_q[i].src1, cdb_i);
        slot_q[i].src2 <= wakeup(slot_q[i].src2, cdb_i);
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/execute_alu.sv
`timescale 1ns/1ps
`default_nettype none

module execute_alu (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               flush_i,
  input  logic               issue_valid_i,
  input  uop_pkg::iq_entry_t issue_entry_i,
  output uop_pkg::cdb_t      cdb_o
);

  logic [backend_cfg_pkg::XLEN-1:0] op_a;
  logic [backend_cfg_pkg::XLEN-1:0] op_b;
  logic [backend_cfg_pkg::XLEN-1:0] result;

  assign op_a = issue_entry_i.src1.value;
  assign op_b = (issue_entry_i.op == uop_pkg::OP_ADDI) ? issue_entry_i.imm
                                                        : issue_entry_i.src2.value;

  always_comb begin
    case (issue_entry_i.op)
      uop_pkg::OP_ADD,
      uop_pkg::OP_ADDI: result = op_a + op_b;
      uop_pkg::OP_SUB:  result = op_a - op_b;
      uop_pkg::OP_AND:  result = op_a & op_b;
      uop_pkg::OP_OR:   result = op_a | op_b;
      uop_pkg::OP_XOR:  result = op_a ^ op_b;
      uop_pkg::OP_SLL:  result = op_a << op_b[4:0];
      uop_pkg::OP_SRL:  result = op_a >> op_b[4:0];
      default:          result = '0;
    endcase
  end

  // One cycle from issue to the result bus
  always_ff @(posedge clk_i) begin
    if (!rst_n_i || flush_i) begin
      cdb_o.valid <= 1'b0;
    end else begin
      cdb_o.valid <= issue_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    cdb_o.tag  <= issue_entry_i.dst;
    cdb_o.data <= result;
  end

endmodule

`default_nettype wire

// File: rtl/rename_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

module rename_dispatch (
  input  logic                                    clk_i,
  input  logic                                    rst_n_i,
  input  logic                                    flush_i,
  input  logic                                    dispatch_valid_i,
  input  uop_pkg::uop_t                           dispatch_uop_i,
  input  logic                                    rob_alloc_ready_i,
  input  backend_cfg_pkg::rob_tag_t               rob_alloc_tag_i,
  input  logic                                    iq_ready_i,
  input  logic [1:0]                              rob_query_ready_i,
  input  logic [1:0][backend_cfg_pkg::XLEN-1:0]   rob_query_data_i,
  input  logic [1:0][backend_cfg_pkg::XLEN-1:0]   arf_rdata_i,
  input  uop_pkg::cdb_t                           cdb_i,
  input  logic                                    commit_fire_i,
  input  backend_cfg_pkg::rob_tag_t               commit_tag_i,
  output logic                                    dispatch_ready_o,
  output logic                                    rob_alloc_valid_o,
  output logic [backend_cfg_pkg::AREG_W-1:0]      rob_alloc_rd_o,
  output logic                                    iq_push_o,
  output uop_pkg::iq_entry_t                      iq_entry_o,
  output backend_cfg_pkg::rob_tag_t [1:0]         rob_query_tag_o,
  output logic [1:0][backend_cfg_pkg::AREG_W-1:0] arf_raddr_o
);

  localparam int unsigned NUM_AREGS = backend_cfg_pkg::NUM_AREGS;

  // Alias table, busy means the newest value still lives in the ROB
  logic [NUM_AREGS-1:0]      busy_q;
  backend_cfg_pkg::rob_tag_t table_tag [NUM_AREGS];
  logic                      alloc_fire;

  function automatic uop_pkg::operand_t source_operand(
    input logic [backend_cfg_pkg::AREG_W-1:0] areg,
    input logic [backend_cfg_pkg::XLEN-1:0]   arf_val,
    input logic                               q_ready,
    input logic [backend_cfg_pkg::XLEN-1:0]   q_data
  );
    uop_pkg::operand_t opnd;
    opnd.ready = 1'b1;
    opnd.tag   = table_tag[areg];
    opnd.value = arf_val;
    if (busy_q[areg]) begin
      // A tag handed out this cycle holds no result yet
      if (q_ready && !(alloc_fire && opnd.tag == rob_alloc_tag_i)) begin
        opnd.value = q_data;
      end else if (cdb_i.valid && cdb_i.tag == opnd.tag) begin
        opnd.value = cdb_i.data;
      end else begin
        opnd.ready = 1'b0;
        opnd.value = '0;
      end
    end
    return opnd;
  endfunction

  assign dispatch_ready_o  = rob_alloc_ready_i && iq_ready_i && !flush_i;
  assign alloc_fire        = dispatch_valid_i && dispatch_ready_o;
  assign rob_alloc_valid_o = alloc_fire;
  assign rob_alloc_rd_o    = dispatch_uop_i.rd;
  assign iq_push_o         = alloc_fire;

  always_comb begin
    arf_raddr_o[0]     = dispatch_uop_i.rs1;
    arf_raddr_o[1]     = dispatch_uop_i.rs2;
    rob_query_tag_o[0] = table_tag[dispatch_uop_i.rs1];
    rob_query_tag_o[1] = table_tag[dispatch_uop_i.rs2];

    iq_entry_o.op   = dispatch_uop_i.op;
    iq_entry_o.imm  = dispatch_uop_i.imm;
    iq_entry_o.dst  = rob_alloc_tag_i;
    iq_entry_o.src1 = source_operand(dispatch_uop_i.rs1, arf_rdata_i[0],
                                     rob_query_ready_i[0], rob_query_data_i[0]);
    iq_entry_o.src2 = source_operand(dispatch_uop_i.rs2, arf_rdata_i[1],
                                     rob_query_ready_i[1], rob_query_data_i[1]);
    // Immediate form never waits on rs2
    if (dispatch_uop_i.op == uop_pkg::OP_ADDI) begin
      iq_entry_o.src2 = '{ready: 1'b1, tag: '0, value: '0};
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || flush_i) begin
      busy_q <= '0;
    end else begin
      for (int r = 0; r < NUM_AREGS; r++) begin
        if (commit_fire_i && busy_q[r] && table_tag[r] == commit_tag_i) begin
          busy_q[r] <= 1'b0;
        end
      end
      // New rename wins over a retiring older writer
      if (alloc_fire && dispatch_uop_i.rd != '0) begin
        busy_q[dispatch_uop_i.rd] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (alloc_fire) begin
      table_tag[dispatch_uop_i.rd] <= rob_alloc_tag_i;
    end
  end

endmodule

`default_nettype wire

// File: rtl/backend_top.sv
`timescale 1ns/1ps
`default_nettype none

module backend_top #(
  parameter int unsigned ROB_DEPTH = 8,
  parameter int unsigned IQ_DEPTH  = 4
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             flush_i,
  input  logic             dispatch_valid_i,
  output logic             dispatch_ready_o,
  input  uop_pkg::uop_t    dispatch_uop_i,
  output logic             commit_valid_o,
  input  logic             commit_ready_i,
  output uop_pkg::commit_t commit_o
);

  logic                                         rob_alloc_ready;
  logic                                         rob_alloc_valid;
  backend_cfg_pkg::rob_tag_t                    rob_alloc_tag;
  logic [backend_cfg_pkg::AREG_W-1:0]           rob_alloc_rd;
  backend_cfg_pkg::rob_tag_t [1:0]              rob_query_tag;
  logic [1:0]                                   rob_query_ready;
  logic [1:0][backend_cfg_pkg::XLEN-1:0]        rob_query_data;
  logic [1:0][backend_cfg_pkg::AREG_W-1:0]      arf_raddr;
  logic [1:0][backend_cfg_pkg::XLEN-1:0]        arf_rdata;
  logic                                         iq_ready;
  logic                                         iq_push;
  uop_pkg::iq_entry_t                           iq_entry;
  logic                                         issue_valid;
  uop_pkg::iq_entry_t                           issue_entry;
  uop_pkg::cdb_t                                cdb;
  logic                                         commit_fire;
  backend_cfg_pkg::rob_tag_t                    commit_tag;

  // ========================================
  // Rename and dispatch
  // ========================================
  rename_dispatch u_rename_dispatch (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .flush_i           (flush_i),
    .dispatch_valid_i  (dispatch_valid_i),
    .dispatch_uop_i    (dispatch_uop_i),
    .rob_alloc_ready_i (rob_alloc_ready),
    .rob_alloc_tag_i   (rob_alloc_tag),
    .iq_ready_i        (iq_ready),
    .rob_query_ready_i (rob_query_ready),
    .rob_query_data_i  (rob_query_data),
    .arf_rdata_i       (arf_rdata),
    .cdb_i             (cdb),
    .commit_fire_i     (commit_fire),
    .commit_tag_i      (commit_tag),
    .dispatch_ready_o  (dispatch_ready_o),
    .rob_alloc_valid_o (rob_alloc_valid),
    .rob_alloc_rd_o    (rob_alloc_rd),
    .iq_push_o         (iq_push),
    .iq_entry_o        (iq_entry),
    .rob_query_tag_o   (rob_query_tag),
    .arf_raddr_o       (arf_raddr)
  );

  // ========================================
  // ROB and architectural state
  // ========================================
  rob #(
    .ROB_DEPTH (ROB_DEPTH)
  ) u_rob (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .flush_i        (flush_i),
    .alloc_valid_i  (rob_alloc_valid),
    .alloc_rd_i     (rob_alloc_rd),
    .cdb_i          (cdb),
    .query_tag_i    (rob_query_tag),
    .commit_ready_i (commit_ready_i),
    .alloc_ready_o  (rob_alloc_ready),
    .alloc_tag_o    (rob_alloc_tag),
    .query_ready_o  (rob_query_ready),
    .query_data_o   (rob_query_data),
    .commit_valid_o (commit_valid_o),
    .commit_o       (commit_o),
    .commit_fire_o  (commit_fire),
    .commit_tag_o   (commit_tag)
  );

  arf u_arf (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .we_i    (commit_fire),
    .waddr_i (commit_o.areg),
    .wdata_i (commit_o.data),
    .raddr_i (arf_raddr),
    .rdata_o (arf_rdata)
  );

  // ========================================
  // Issue and execute
  // ========================================
  issue_queue #(
    .IQ_DEPTH (IQ_DEPTH)
  ) u_issue_queue (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .flush_i       (flush_i),
    .push_i        (iq_push),
    .entry_i       (iq_entry),
    .cdb_i         (cdb),
    .ready_o       (iq_ready),
    .issue_valid_o (issue_valid),
    .issue_entry_o (issue_entry)
  );

  execute_alu u_execute_alu (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .flush_i       (flush_i),
    .issue_valid_i (issue_valid),
    .issue_entry_i (issue_entry),
    .cdb_o         (cdb)
  );

endmodule

`default_nettype wire

// File: dv/tb_backend.sv
`timescale 1ns/1ps
`default_nettype none

module tb_backend;

  localparam int unsigned ROB_DEPTH = 8;
  localparam int unsigned IQ_DEPTH  = 4;
  localparam int CM_ALWAYS = 0;
  localparam int CM_RANDOM = 1;
  localparam int CM_HOLD   = 2;

  logic             clk_i;
  logic             rst_n_i;
  logic             flush_i;
  logic             dispatch_valid_i;
  logic             dispatch_ready_o;
  uop_pkg::uop_t    dispatch_uop_i;
  logic             commit_valid_o;
  logic             commit_ready_i;
  uop_pkg::commit_t commit_o;

  logic [31:0]                                                       lfsr_q;
  logic [backend_cfg_pkg::NUM_AREGS-1:0][backend_cfg_pkg::XLEN-1:0] ref_regs;
  uop_pkg::uop_t pending [$];
  int            commit_mode;
  int            n_sent;
  int            cycle_cnt;

  backend_top #(
    .ROB_DEPTH (ROB_DEPTH),
    .IQ_DEPTH  (IQ_DEPTH)
  ) u_backend_top (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .flush_i          (flush_i),
    .dispatch_valid_i (dispatch_valid_i),
    .dispatch_ready_o (dispatch_ready_o),
    .dispatch_uop_i   (dispatch_uop_i),
    .commit_valid_o   (commit_valid_o),
    .commit_ready_i   (commit_ready_i),
    .commit_o         (commit_o)
  );

  always #4 clk_i = ~clk_i;

  // ========================================
  // Helpers
  // ========================================
  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] rand_bits(input int nbits);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < nbits; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      val    = {val[30:0], fb};
    end
    return val;
  endfunction

  function automatic uop_pkg::uop_t random_uop(input int reg_bits);
    uop_pkg::uop_t u;
    logic [31:0]   r;
    r     = rand_bits(3);
    u.op  = uop_pkg::alu_op_e'(r[2:0]);
    u.rd  = 5'(rand_bits(reg_bits));
    u.rs1 = 5'(rand_bits(reg_bits));
    u.rs2 = 5'(rand_bits(reg_bits));
    u.imm = rand_bits(32);
    return u;
  endfunction

  // Expected result straight from the opcode rules
  function automatic logic [31:0] ref_result(
    input uop_pkg::uop_t u,
    input logic [31:0][31:0] regs
  );
    logic [31:0] a;
    logic [31:0] b;
    a = (u.rs1 == 5'd0) ? 32'd0 : regs[u.rs1];
    b = (u.rs2 == 5'd0) ? 32'd0 : regs[u.rs2];
    case (u.op)
      uop_pkg::OP_ADD:  return a + b;
      uop_pkg::OP_SUB:  return a - b;
      uop_pkg::OP_AND:  return a & b;
      uop_pkg::OP_OR:   return a | b;
      uop_pkg::OP_XOR:  return a ^ b;
      uop_pkg::OP_SLL:  return a << b[4:0];
      uop_pkg::OP_SRL:  return a >> b[4:0];
      default:          return a + u.imm;
    endcase
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("FAILED at %0t ns: %s = 0x%08h, expected 0x%08h",
                          $time, name, got, exp));
    end
  endtask

  // One clock with commit ready set by the current mode
  task automatic tick();
    @(posedge clk_i);
    case (commit_mode)
      CM_ALWAYS: commit_ready_i <= 1'b1;
      CM_RANDOM: commit_ready_i <= (rand_bits(1) != 32'd0);
      default:   commit_ready_i <= 1'b0;
    endcase
  endtask

  task automatic send_uop(input uop_pkg::uop_t u);
    n_sent++;
    dispatch_valid_i <= 1'b1;
    dispatch_uop_i   <= u;
    do begin
      tick();
    end while (!dispatch_ready_o);
    dispatch_valid_i <= 1'b0;
  endtask

  task automatic pulse_flush();
    flush_i <= 1'b1;
    tick();
    flush_i <= 1'b0;
  endtask

  task automatic wait_drain();
    do begin
      tick();
      @(negedge clk_i);
    end while (pending.size() != 0);
    tick();
  endtask

  // ========================================
  // Scoreboard
  // ========================================
  always @(posedge clk_i) begin : compare_proc
    uop_pkg::uop_t u;
    logic [31:0]   exp;
    if (rst_n_i) begin
      if (flush_i) begin
        check_value("commit_valid_o", 32'(commit_valid_o), 32'd0);
        check_value("dispatch_ready_o", 32'(dispatch_ready_o), 32'd0);
        pending.delete();
      end else begin
        if (commit_valid_o && commit_ready_i) begin
          if (pending.size() == 0) begin
            abort_run("A commit happened with no uop in flight");
          end else begin
            u   = pending.pop_front();
            exp = ref_result(u, ref_regs);
            check_value("commit_o.areg", 32'(commit_o.areg), 32'(u.rd));
            check_value("commit_o.data", commit_o.data, exp);
            if (u.rd != 5'd0) begin
              ref_regs[u.rd] = exp;
            end
          end
        end
        if (dispatch_valid_i && dispatch_ready_o) begin
          pending.push_back(dispatch_uop_i);
        end
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt > 40 * n_sent + 500) begin
      abort_run("Timeout: the uops did not all commit within the cycle budget");
    end
  end

  // ========================================
  // Stimulus
  // ========================================
  initial begin
    uop_pkg::uop_t u;
    logic [4:0]    prev_rd;
    int            accepted;
    clk_i            = 1'b0;
    rst_n_i          = 1'b0;
    flush_i          = 1'b0;
    dispatch_valid_i = 1'b0;
    dispatch_uop_i   = '0;
    commit_ready_i   = 1'b0;
    lfsr_q           = 32'h3465_7dab;
    ref_regs         = '0;
    commit_mode      = CM_ALWAYS;
    n_sent           = 0;
    cycle_cnt        = 0;
    repeat (8) tick();
    rst_n_i <= 1'b1;

    // Idle after reset
    repeat (10) begin
      tick();
      check_value("commit_valid_o", 32'(commit_valid_o), 32'd0);
    end

    // Seed x1..x8 then run every opcode once
    for (int i = 1; i <= 8; i++) begin
      send_uop('{op: uop_pkg::OP_ADDI, rd: 5'(i), rs1: 5'd0, rs2: 5'd0, imm: rand_bits(32)});
    end
    for (int i = 0; i < 8; i++) begin
      send_uop('{op: uop_pkg::alu_op_e'(i), rd: 5'(16 + i), rs1: 5'(1 + i),
                 rs2: 5'(8 - i), imm: rand_bits(32)});
    end
    wait_drain();

    // Dependent chain through rs1
    prev_rd = 5'd1;
    for (int i = 0; i < 40; i++) begin
      u     = random_uop(3);
      u.rs1 = prev_rd;
      if (u.rd != 5'd0) begin
        prev_rd = u.rd;
      end
      send_uop(u);
    end
    wait_drain();

    commit_mode = CM_RANDOM;
    for (int i = 0; i < 60; i++) begin
      send_uop(random_uop(3));
    end
    commit_mode = CM_ALWAYS;
    wait_drain();

    // Commit held off until the ROB fills
    commit_mode = CM_HOLD;
    tick();
    accepted = 0;
    u        = random_uop(3);
    n_sent++;
    for (int c = 0; c < 40; c++) begin
      dispatch_valid_i <= 1'b1;
      dispatch_uop_i   <= u;
      tick();
      if (dispatch_ready_o) begin
        accepted++;
        u = random_uop(3);
        n_sent++;
      end
    end
    dispatch_valid_i <= 1'b0;
    check_value("accepted uops", 32'(accepted), 32'(ROB_DEPTH));
    check_value("dispatch_ready_o", 32'(dispatch_ready_o), 32'd0);
    // Head is done and waits for the handshake
    check_value("commit_valid_o", 32'(commit_valid_o), 32'd1);
    commit_mode = CM_ALWAYS;
    wait_drain();

    // Flush in the middle of a stream
    commit_mode = CM_RANDOM;
    for (int i = 0; i < 12; i++) begin
      send_uop(random_uop(3));
    end
    pulse_flush();
    for (int i = 0; i < 12; i++) begin
      send_uop(random_uop(3));
    end
    commit_mode = CM_ALWAYS;
    wait_drain();

    // Mixed traffic
    commit_mode = CM_RANDOM;
    for (int i = 0; i < 200; i++) begin
      while (rand_bits(2) == 32'd0) begin
        tick();
      end
      if (rand_bits(5) == 32'd0) begin
        pulse_flush();
      end
      send_uop(random_uop(3));
    end
    commit_mode = CM_ALWAYS;
    wait_drain();
    repeat (4) tick();

    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
rtl/backend_cfg_pkg.sv
rtl/uop_pkg.sv
rtl/arf.sv
rtl/rob.sv
rtl/issue_queue.sv
rtl/execute_alu.sv
rtl/rename_dispatch.sv
rtl/backend_top.sv
dv/tb_backend.sv

// File: run_sim.sh
#!/bin/sh
verilator --binary --timing --timescale 1ns/1ps --top-module tb_backend -f project.f \
  -o sim_backend > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_backend > sim.log 2>&1 || true
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1
grep -q "TEST OK" sim.log || exit 1
exit 0
